/* common/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// first fetch address out of reset
`define CORE_RESET_PC 32'h80000000

`define CORE_NUM_REGS 32

// fixed SYSTEM encodings
`define CORE_INSTR_WFI    32'h10500073
`define CORE_INSTR_ECALL  32'h00000073
`define CORE_INSTR_EBREAK 32'h00100073

`endif

/* common/rv32_types_pkg.sv */
package rv32_types_pkg;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [2:0] {
        FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK, WAIT_INT, HALTED
    } ctrl_state_t;

    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        alu_op_t     alu_op;
        logic        use_imm;   // operand b from imm instead of rs2
        logic        is_load;
        logic        is_store;
        logic        is_branch;
        logic        branch_ne;
        logic        reg_write;
        logic        is_wfi;
        logic        is_halt;
        logic        illegal;
    } decoded_t;

    typedef struct packed {
        logic [31:0] alu_value;
        logic [31:0] mem_addr;
        logic [31:0] store_data;
        logic        branch_taken;
        logic [31:0] branch_target;
    } result_t;

    typedef struct packed {
        logic        ren;
        logic        wen;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  byte_en;
    } bus_req_t;

endpackage

/* core/core_control.sv */
`include "core_cfg.svh"

module core_control import rv32_types_pkg::*; (
    input  logic        CLK,
    input  logic        rst,
    input  logic        busy,
    input  logic        error,
    input  logic        ext_int,
    input  logic [31:0] rdata,
    input  decoded_t    dec,
    input  result_t     res,
    output bus_req_t    bus,
    output logic [31:0] pc,
    output logic [31:0] instr,
    output logic [31:0] load_data,
    output logic        wb_en,
    output logic        wfi,
    output logic        halt
);

    ctrl_state_t state, state_nxt;
    bus_req_t    bus_nxt;
    logic [31:0] pc_nxt;
    logic        done;

    assign done = (bus.ren || bus.wen) && !busy; // access completes this cycle

    // pc only moves in writeback
    assign pc_nxt = (state != WRITEBACK) ? pc :
                    res.branch_taken ? res.branch_target : pc + 32'd4;

    always_comb begin
        state_nxt = state;
        case (state)
            FETCH, MEMORY: begin
                if (done) begin
                    if (error) begin
                        state_nxt = HALTED;
                    end else begin
                        state_nxt = (state == FETCH) ? DECODE : WRITEBACK;
                    end
                end
            end
            DECODE:    state_nxt = EXECUTE;
            EXECUTE: begin
                if (dec.is_halt || dec.illegal) begin
                    state_nxt = HALTED;
                end else if (dec.is_wfi) begin
                    state_nxt = WAIT_INT;
                end else if (dec.is_load || dec.is_store) begin
                    state_nxt = MEMORY;
                end else begin
                    state_nxt = WRITEBACK;
                end
            end
            WRITEBACK: state_nxt = FETCH;
            WAIT_INT:  state_nxt = ext_int ? WRITEBACK : WAIT_INT;
            default:   state_nxt = HALTED;
        endcase
    end

    // request is registered so it is up in the first cycle of fetch/memory
    always_comb begin
        bus_nxt = '0;
        if (state_nxt == FETCH) begin
            bus_nxt.ren     = 1'b1;
            bus_nxt.addr    = pc_nxt;
            bus_nxt.byte_en = 4'hf;
        end else if (state_nxt == MEMORY) begin
            bus_nxt.ren     = dec.is_load;
            bus_nxt.wen     = dec.is_store;
            bus_nxt.addr    = res.mem_addr;
            bus_nxt.wdata   = res.store_data;
            bus_nxt.byte_en = 4'hf; // word access only
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= FETCH;
            pc    <= `CORE_RESET_PC;
            bus   <= '0;
        end else begin
            state <= state_nxt;
            pc    <= pc_nxt;
            bus   <= bus_nxt;
        end
    end

    always_ff @(posedge CLK) begin
        if (state == FETCH && done) begin
            instr <= rdata;
        end
        if (state == MEMORY && done && dec.is_load) begin
            load_data <= rdata;
        end
    end

    assign wb_en = (state == WRITEBACK);
    assign wfi   = (state == WAIT_INT);
    assign halt  = (state == HALTED);

    a_one_dir: assert property (@(posedge CLK) disable iff (rst) !(bus.ren && bus.wen));
    a_hold_busy: assert property (@(posedge CLK) disable iff (rst)
        (bus.ren || bus.wen) && busy |=> $stable(bus));
    a_halt_sticky: assert property (@(posedge CLK) $fell(halt) |-> $past(rst));

endmodule

/* core/instr_decode.sv */
`include "core_cfg.svh"

module instr_decode import rv32_types_pkg::*; (
    input  logic [31:0] instr,
    output decoded_t    dec
);

    opcode_t     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i, imm_s, imm_b, imm_u;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        dec     = '0;
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.rd  = instr[11:7];
        case (opcode)
            OPC_LUI: begin
                dec.imm       = imm_u;
                dec.alu_op    = ALU_PASS_B;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            OPC_OP_IMM, OPC_OP: begin
                dec.imm       = imm_i;
                dec.use_imm   = (opcode == OPC_OP_IMM);
                dec.reg_write = 1'b1;
                case (funct3)
                    3'b000: dec.alu_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
                    3'b100: dec.alu_op = ALU_XOR;
                    3'b110: dec.alu_op = ALU_OR;
                    3'b111: dec.alu_op = ALU_AND;
                    default: dec.illegal = 1'b1;
                endcase
                // R-type only allows funct7 0, or 0x20 for sub
                if (opcode == OPC_OP && funct7 != 7'b0 &&
                        !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
                    dec.illegal = 1'b1;
                end
            end
            OPC_LOAD: begin
                dec.imm       = imm_i;
                dec.is_load   = 1'b1;
                dec.reg_write = 1'b1;
                dec.illegal   = (funct3 != 3'b010); // lw only
            end
            OPC_STORE: begin
                dec.imm      = imm_s;
                dec.is_store = 1'b1;
                dec.illegal  = (funct3 != 3'b010);
            end
            OPC_BRANCH: begin
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
                dec.branch_ne = funct3[0];
                dec.illegal   = (funct3[2:1] != 2'b00); // beq/bne
            end
            OPC_SYSTEM: begin
                dec.is_wfi  = (instr == `CORE_INSTR_WFI);
                dec.is_halt = (instr == `CORE_INSTR_ECALL) || (instr == `CORE_INSTR_EBREAK);
                dec.illegal = !dec.is_wfi && !dec.is_halt;
            end
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

/* core/alu_execute.sv */
module alu_execute import rv32_types_pkg::*; (
    input  decoded_t    dec,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_value,
    input  logic [31:0] rs2_value,
    output result_t     res
);

    logic [31:0] operand_b;
    logic [31:0] alu_out;
    logic        operands_eq;

    assign operand_b = dec.use_imm ? dec.imm : rs2_value;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:    alu_out = rs1_value + operand_b;
            ALU_SUB:    alu_out = rs1_value - operand_b;
            ALU_AND:    alu_out = rs1_value & operand_b;
            ALU_OR:     alu_out = rs1_value | operand_b;
            ALU_XOR:    alu_out = rs1_value ^ operand_b;
            ALU_PASS_B: alu_out = operand_b; // lui
            default:    alu_out = '0;
        endcase
    end

    assign operands_eq = (rs1_value == rs2_value);

    always_comb begin
        res.alu_value     = alu_out;
        res.mem_addr      = rs1_value + dec.imm;
        res.store_data    = rs2_value;
        res.branch_target = pc + dec.imm;
        res.branch_taken  = 1'b0;
        if (dec.is_branch) begin
            res.branch_taken = dec.branch_ne ? !operands_eq : operands_eq;
        end
    end

endmodule

/* core/result_writeback.sv */
`include "core_cfg.svh"

module result_writeback import rv32_types_pkg::*; (
    input  logic        CLK,
    input  logic        rst,
    input  decoded_t    dec,
    input  result_t     res,
    input  logic [31:0] load_data,
    input  logic        wb_en,
    output logic [31:0] rs1_value,
    output logic [31:0] rs2_value
);

    logic [31:0] regs [`CORE_NUM_REGS];
    logic [31:0] wb_value;
    logic        wr;

    assign wb_value = dec.is_load ? load_data : res.alu_value;
    assign wr       = wb_en && dec.reg_write && (dec.rd != 5'd0); // x0 never written

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr) begin
            regs[dec.rd] <= wb_value;
        end
    end

    // async read ports settle before execute
    assign rs1_value = regs[dec.rs1];
    assign rs2_value = regs[dec.rs2];

endmodule

/* source/top_core.sv */
module top_core import rv32_types_pkg::*; (
    input  logic        CLK,
    input  logic        rst,
    input  logic        busy,
    input  logic        error,
    input  logic [31:0] rdata,
    input  logic        ext_int,
    output logic        ren,
    output logic        wen,
    output logic [3:0]  byte_en,
    output logic [31:0] addr,
    output logic [31:0] wdata,
    output logic        wfi,
    output logic        halt
);

    bus_req_t    bus;
    decoded_t    dec;
    result_t     res;
    logic [31:0] pc, instr, load_data;
    logic [31:0] rs1_value, rs2_value;
    logic        wb_en;

    core_control u_ctrl (
        .CLK(CLK), .rst(rst), .busy(busy), .error(error), .ext_int(ext_int),
        .rdata(rdata), .dec(dec), .res(res), .bus(bus), .pc(pc), .instr(instr),
        .load_data(load_data), .wb_en(wb_en), .wfi(wfi), .halt(halt)
    );

    instr_decode u_dec (.instr(instr), .dec(dec));

    alu_execute u_exe (.dec(dec), .pc(pc), .rs1_value(rs1_value), .rs2_value(rs2_value), .res(res));

    result_writeback u_wb (
        .CLK(CLK), .rst(rst), .dec(dec), .res(res), .load_data(load_data),
        .wb_en(wb_en), .rs1_value(rs1_value), .rs2_value(rs2_value)
    );

    assign {ren, wen, addr, wdata, byte_en} = bus;

endmodule

/* verification/tb_top_core.sv */
`include "core_cfg.svh"

module tb_top_core import rv32_types_pkg::*; ();

    localparam int PROG_LEN = 29;
    localparam int NUM_STORES = 10;
    localparam int LIMIT = 2 * (PROG_LEN * 5 * 4 + 200) + 40;
    localparam logic [31:0] BASE = `CORE_RESET_PC;

    logic CLK, rst, busy, error, ext_int, ren, wen, wfi, halt;
    logic [31:0] rdata, addr, wdata;
    logic [3:0] byte_en;
    bus_req_t cur_req, held_req, exp_req;
    logic [31:0] mem [256];
    logic [31:0] prog [PROG_LEN];
    logic [31:0] exp_addr [NUM_STORES];
    logic [31:0] exp_data [NUM_STORES];
    logic [31:0] v1, v2, v3, v4, v5, v6, v7;
    int store_idx, stall, cycles;
    logic active, err_fetch;

    top_core dut0 (.CLK(CLK), .rst(rst), .busy(busy), .error(error), .rdata(rdata),
        .ext_int(ext_int), .ren(ren), .wen(wen), .byte_en(byte_en), .addr(addr),
        .wdata(wdata), .wfi(wfi), .halt(halt));

    assign cur_req = {ren, wen, addr, wdata, byte_en};

    function automatic logic [31:0] fill_word(logic [31:0] a);
        return a ^ 32'h5a5a_c3c3; // depends on every address bit
    endfunction

    function automatic logic [31:0] enc_i(logic [6:0] op, logic [4:0] rd, logic [4:0] rs1,
                                          logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_s(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic stop_run(string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_bus(bus_req_t got, bus_req_t exp, string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t: %s, got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        ctrl_state_t st;
        st = dut0.u_ctrl.state;
        cycles++;
        if (cycles > LIMIT) begin
            stop_run($sformatf("timeout after %0d cycles, core stuck in state %s",
                               cycles, st.name()));
        end
    end

    // bus memory model with random stalls of 0 to 3 cycles per access
    always @(negedge CLK) begin
        if (rst) begin
            active = 1'b0;
            busy   = 1'b0;
            error  = 1'b0;
        end else begin
            error = 1'b0;
            if (active && !busy) active = 1'b0; // completed on last rising edge
            if (active) begin
                check_bus(cur_req, held_req, "request changed while busy");
            end else if (cur_req.ren || cur_req.wen) begin
                active   = 1'b1;
                held_req = cur_req;
                stall    = $urandom % 4;
                exp_req  = cur_req;
                exp_req.byte_en = 4'hf;
                check_bus(cur_req, exp_req, "byte_en not all ones");
            end
            busy = active && (stall > 0);
            if (busy) begin
                stall--;
            end else if (active && cur_req.ren) begin
                rdata = mem[addr[9:2]];
                error = err_fetch;
            end else if (active && cur_req.wen) begin
                if (store_idx >= NUM_STORES) stop_run("store seen after the last expected one");
                exp_req = '{ren: 1'b0, wen: 1'b1, addr: exp_addr[store_idx],
                            wdata: exp_data[store_idx], byte_en: 4'hf};
                check_bus(cur_req, exp_req, $sformatf("store %0d", store_idx));
                mem[addr[9:2]] = wdata;
                store_idx++;
            end
        end
    end

    initial begin
        void'($urandom(32'h3ad2));
        rst = 1'b1;
        busy = 1'b0;
        error = 1'b0;
        rdata = '0;
        ext_int = 1'b0;
        err_fetch = 1'b0;
        store_idx = 0;
        cycles = 0;
        active = 1'b0;
        stall = 0;
        prog = '{32'h80000537, 32'h123450b7, enc_i(7'h13, 1, 1, 12'h678),
            enc_i(7'h13, 2, 0, 12'hfff), enc_r(7'h00, 0, 3, 1, 2), enc_s(3, 10, 12'h300),
            enc_r(7'h20, 0, 4, 1, 2), enc_r(7'h00, 3'b111, 5, 1, 4),
            enc_r(7'h00, 3'b110, 6, 3, 4), enc_r(7'h00, 3'b100, 7, 1, 2),
            enc_s(4, 10, 12'h304), enc_s(5, 10, 12'h308), enc_s(6, 10, 12'h30c),
            enc_s(7, 10, 12'h310), enc_i(7'h13, 0, 0, 12'd5), enc_s(0, 10, 12'h314),
            enc_i(7'h03, 8, 10, 12'h200) | 32'h2000, enc_s(8, 10, 12'h318),
            enc_b(3'b000, 1, 5, 13'd8), enc_s(2, 10, 12'h31c), enc_b(3'b001, 1, 5, 13'd8),
            enc_s(3, 10, 12'h320), enc_b(3'b001, 1, 2, 13'd8), enc_s(2, 10, 12'h324),
            enc_b(3'b000, 1, 2, 13'd8), enc_s(4, 10, 12'h328), `CORE_INSTR_WFI,
            enc_s(5, 10, 12'h32c), `CORE_INSTR_ECALL};
        for (int i = 0; i < 256; i++) mem[i] = fill_word(BASE + 32'(i * 4));
        for (int i = 0; i < PROG_LEN; i++) mem[i] = prog[i];
        v1 = 32'h12345000 + 32'h678;
        v2 = 32'd0 - 32'd1;
        v3 = v1 + v2;
        v4 = v1 - v2;
        v5 = v1 & v4;
        v6 = v3 | v4;
        v7 = v1 ^ v2;
        exp_addr = '{BASE + 'h300, BASE + 'h304, BASE + 'h308, BASE + 'h30c, BASE + 'h310,
                     BASE + 'h314, BASE + 'h318, BASE + 'h320, BASE + 'h328, BASE + 'h32c};
        exp_data = '{v3, v4, v5, v6, v7, 32'd0, fill_word(BASE + 'h200), v3, v4, v5};
        repeat (4) begin
            @(negedge CLK);
            check_flag(ren | wen | wfi | halt, 1'b0, "outputs during reset");
        end
        rst = 1'b0;
        @(negedge CLK);
        check_bus(cur_req, '{1'b1, 1'b0, BASE, 32'd0, 4'hf}, "first fetch");
        while (!wfi) @(negedge CLK);
        repeat (6) begin
            @(negedge CLK);
            check_flag(ren, 1'b0, "ren while waiting for interrupt");
            check_flag(wfi, 1'b1, "wfi");
        end
        ext_int = 1'b1;
        while (!ren) @(negedge CLK);
        ext_int = 1'b0;
        check_bus(cur_req, '{1'b1, 1'b0, BASE + 32'd108, 32'd0, 4'hf}, "fetch after wake-up");
        while (!halt) @(negedge CLK);
        if (store_idx != NUM_STORES) stop_run("not every expected store was seen");
        repeat (5) begin
            @(negedge CLK);
            check_flag(ren | wen, 1'b0, "bus request after ecall");
            check_flag(halt, 1'b1, "halt after ecall");
        end
        // second run with a bus error on the first fetch
        rst = 1'b1;
        err_fetch = 1'b1;
        repeat (4) @(negedge CLK);
        rst = 1'b0;
        while (!halt) @(negedge CLK);
        repeat (5) begin
            @(negedge CLK);
            check_flag(ren | wen, 1'b0, "bus request after bus error");
            check_flag(halt, 1'b1, "halt after bus error");
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* build.f */
+incdir+common
common/rv32_types_pkg.sv
core/core_control.sv
core/instr_decode.sv
core/alu_execute.sv
core/result_writeback.sv
source/top_core.sv
verification/tb_top_core.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_top_core
FILELIST  ?= build.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
